// ==== procci_harness.f ====
rtl/bus_pkg.sv
rtl/host_pkg.sv
rtl/credit_fifo.sv
rtl/wb_mem_port.sv
rtl/host_cmd_engine.sv
rtl/procci_harness_top.sv
test/procci_harness_assertions.sv
test/tb_procci_harness.sv

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // Both core buses use byte addresses and carry whole words
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Word index starts above the byte offset bits
  localparam int WORD_BYTES = DATA_W / 8;
  localparam int WORD_LSB   = $clog2(WORD_BYTES);

  // Depth of each memory, in words
  localparam int unsigned MEM_WORDS_DEFAULT = 256;

endpackage

`default_nettype wire

// ==== rtl/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = host_pkg::CMD_DEPTH_DEFAULT
) (
  input  logic sys_clk,
  input  logic arst_n_i,
  input  logic push_i,
  input  T     push_data_i,
  input  logic pop_i,
  output T     pop_data_o,
  output logic empty_o,
  output logic credit_o
);

  import host_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  T                 buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  credit_t          count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == credit_t'(DEPTH));
  assign do_push = push_i && !full; // Overflow push is lost
  assign do_pop  = pop_i && !empty_o;

  // Head entry is visible without a pop
  assign pop_data_o = buf_q[rd_ptr_q];

  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      buf_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Both or neither
      endcase
      // One credit back to the host per freed slot
      credit_o <= do_pop;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/host_cmd_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_cmd_engine #(
  parameter int unsigned RSP_CREDITS = host_pkg::RSP_CREDITS_DEFAULT
) (
  input  logic                sys_clk,
  input  logic                arst_n_i,
  input  logic                cmd_empty_i,
  input  host_pkg::host_cmd_t cmd_i,
  output logic                cmd_pop_o,
  input  logic                rsp_credit_i,
  output logic                rsp_valid_o,
  output bus_pkg::data_t      rsp_data_o,
  output logic                host_sel_o,
  output logic                core_rst_n_o,
  output logic                imem_req_o,
  output logic                dmem_req_o,
  output logic                mem_we_o,
  output bus_pkg::addr_t      mem_addr_o,
  output bus_pkg::data_t      mem_wdata_o,
  input  bus_pkg::data_t      imem_rdata_i,
  input  bus_pkg::data_t      dmem_rdata_i
);

  import host_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCESS,
    S_RESPOND
  } state_t;

  state_t    state_q;
  state_t    state_d;
  host_cmd_t cmd_q;
  credit_t   credits_q;
  logic      run_q;
  logic      can_pop;
  logic      have_credit;
  logic      access_go;

  // Respond overlaps with the next pop
  assign can_pop   = (state_q != S_ACCESS) && !cmd_empty_i;
  assign cmd_pop_o = can_pop;

  assign have_credit = (credits_q != '0);

  // Writes go at once, reads wait for a response credit
  assign access_go = (state_q == S_ACCESS) && (!op_is_read(cmd_q.op) || have_credit);

  assign imem_req_o  = access_go && op_is_imem(cmd_q.op);
  assign dmem_req_o  = access_go && !op_is_imem(cmd_q.op);
  assign mem_we_o    = !op_is_read(cmd_q.op);
  assign mem_addr_o  = cmd_q.addr;
  assign mem_wdata_o = cmd_q.data;

  // Read data arrives from the memory one cycle after the request
  assign rsp_valid_o = (state_q == S_RESPOND);
  assign rsp_data_o  = op_is_imem(cmd_q.op) ? imem_rdata_i : dmem_rdata_i;

  assign host_sel_o   = !run_q; // Host owns the memories while halted
  assign core_rst_n_o = run_q;

  always_comb begin
    state_d = S_IDLE;
    case (state_q)
      S_ACCESS: begin
        if (!access_go) begin
          state_d = S_ACCESS; // Stalled on response credit
        end else if (op_is_read(cmd_q.op)) begin
          state_d = S_RESPOND;
        end
      end
      default: begin
        // Memory commands are dropped while the core runs
        if (can_pop && op_is_mem(cmd_i.op) && !run_q) begin
          state_d = S_ACCESS;
        end
      end
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (can_pop) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= S_IDLE;
      run_q     <= 1'b0;
      credits_q <= credit_t'(RSP_CREDITS);
    end else begin
      state_q <= state_d;
      if (can_pop) begin
        if (cmd_i.op == OP_CORE_RUN) begin
          run_q <= 1'b1;
        end else if (cmd_i.op == OP_CORE_HALT) begin
          run_q <= 1'b0;
        end
      end
      // Host return and own spend may meet in one cycle
      case ({rsp_credit_i, rsp_valid_o})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/host_pkg.sv ====
`default_nettype none

package host_pkg;

  // Host command opcodes
  typedef enum logic [2:0] {
    OP_IMEM_WRITE = 3'd0,
    OP_DMEM_WRITE = 3'd1,
    OP_IMEM_READ  = 3'd2,
    OP_DMEM_READ  = 3'd3,
    OP_CORE_RUN   = 3'd4,
    OP_CORE_HALT  = 3'd5
  } host_op_t;

  // One command as it sits in the FIFO, 67 bits
  typedef struct packed {
    host_op_t       op;
    bus_pkg::addr_t addr;
    bus_pkg::data_t data;
  } host_cmd_t;

  localparam int CREDIT_W = 4;
  typedef logic [CREDIT_W-1:0] credit_t;

  localparam int unsigned CMD_DEPTH_DEFAULT   = 4;
  localparam int unsigned RSP_CREDITS_DEFAULT = 2;

  function automatic logic op_is_mem(host_op_t op);
    return (op == OP_IMEM_WRITE) || (op == OP_DMEM_WRITE) ||
           (op == OP_IMEM_READ)  || (op == OP_DMEM_READ);
  endfunction

  function automatic logic op_is_read(host_op_t op);
    return (op == OP_IMEM_READ) || (op == OP_DMEM_READ);
  endfunction

  // Instruction side or data side
  function automatic logic op_is_imem(host_op_t op);
    return (op == OP_IMEM_WRITE) || (op == OP_IMEM_READ);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/procci_harness_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module procci_harness_top #(
  parameter int unsigned MEM_WORDS   = bus_pkg::MEM_WORDS_DEFAULT,
  parameter int unsigned CMD_DEPTH   = host_pkg::CMD_DEPTH_DEFAULT,
  parameter int unsigned RSP_CREDITS = host_pkg::RSP_CREDITS_DEFAULT
) (
  input  logic               sys_clk,
  input  logic               arst_n_i,

  // Host command and response channels
  input  logic               host_cmd_valid_i,
  input  host_pkg::host_op_t host_cmd_op_i,
  input  bus_pkg::addr_t     host_cmd_addr_i,
  input  bus_pkg::data_t     host_cmd_data_i,
  output logic               host_cmd_credit_o,
  output logic               host_rsp_valid_o,
  output bus_pkg::data_t     host_rsp_data_o,
  input  logic               host_rsp_credit_i,
  output logic               core_rst_n_o,

  // Instruction bus, read only
  input  logic               core_cyc_i,
  input  logic               core_stb_i,
  input  bus_pkg::addr_t     core_addr_i,
  output bus_pkg::data_t     core_data_o,
  output logic               core_ack_o,

  // Data bus
  input  logic               data_mem_cyc_i,
  input  logic               data_mem_stb_i,
  input  logic               data_mem_we_i,
  input  bus_pkg::addr_t     data_mem_addr_i,
  input  bus_pkg::data_t     data_mem_data_i,
  output bus_pkg::data_t     data_mem_data_o,
  output logic               data_mem_ack_o
);

  import bus_pkg::*;
  import host_pkg::*;

  host_cmd_t push_cmd;
  host_cmd_t fifo_cmd;
  logic      fifo_empty;
  logic      fifo_pop;
  logic      host_sel;
  logic      imem_req;
  logic      dmem_req;
  logic      mem_we;
  addr_t     mem_addr;
  data_t     mem_wdata;
  data_t     imem_rdata;
  data_t     dmem_rdata;

  assign push_cmd = '{op: host_cmd_op_i, addr: host_cmd_addr_i, data: host_cmd_data_i};

  credit_fifo #(
    .T     (host_cmd_t),
    .DEPTH (CMD_DEPTH)
  ) u_cmd_fifo (
    .sys_clk     (sys_clk),
    .arst_n_i    (arst_n_i),
    .push_i      (host_cmd_valid_i),
    .push_data_i (push_cmd),
    .pop_i       (fifo_pop),
    .pop_data_o  (fifo_cmd),
    .empty_o     (fifo_empty),
    .credit_o    (host_cmd_credit_o)
  );

  host_cmd_engine #(
    .RSP_CREDITS (RSP_CREDITS)
  ) u_engine (
    .sys_clk      (sys_clk),
    .arst_n_i     (arst_n_i),
    .cmd_empty_i  (fifo_empty),
    .cmd_i        (fifo_cmd),
    .cmd_pop_o    (fifo_pop),
    .rsp_credit_i (host_rsp_credit_i),
    .rsp_valid_o  (host_rsp_valid_o),
    .rsp_data_o   (host_rsp_data_o),
    .host_sel_o   (host_sel),
    .core_rst_n_o (core_rst_n_o),
    .imem_req_o   (imem_req),
    .dmem_req_o   (dmem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .imem_rdata_i (imem_rdata),
    .dmem_rdata_i (dmem_rdata)
  );

  // Core never writes the instruction memory
  wb_mem_port #(
    .MEM_WORDS (MEM_WORDS),
    .WRITABLE  (1'b0)
  ) u_imem (
    .sys_clk    (sys_clk),
    .arst_n_i   (arst_n_i),
    .host_sel_i (host_sel),
    .wb_cyc_i   (core_cyc_i),
    .wb_stb_i   (core_stb_i),
    .wb_we_i    (1'b0),
    .wb_addr_i  (core_addr_i),
    .wb_data_i  ('0),
    .wb_data_o  (core_data_o),
    .wb_ack_o   (core_ack_o),
    .h_req_i    (imem_req),
    .h_we_i     (mem_we),
    .h_addr_i   (mem_addr),
    .h_data_i   (mem_wdata),
    .h_rdata_o  (imem_rdata)
  );

  wb_mem_port #(
    .MEM_WORDS (MEM_WORDS),
    .WRITABLE  (1'b1)
  ) u_dmem (
    .sys_clk    (sys_clk),
    .arst_n_i   (arst_n_i),
    .host_sel_i (host_sel),
    .wb_cyc_i   (data_mem_cyc_i),
    .wb_stb_i   (data_mem_stb_i),
    .wb_we_i    (data_mem_we_i),
    .wb_addr_i  (data_mem_addr_i),
    .wb_data_i  (data_mem_data_i),
    .wb_data_o  (data_mem_data_o),
    .wb_ack_o   (data_mem_ack_o),
    .h_req_i    (dmem_req),
    .h_we_i     (mem_we),
    .h_addr_i   (mem_addr),
    .h_data_i   (mem_wdata),
    .h_rdata_o  (dmem_rdata)
  );

endmodule

`default_nettype wire

// ==== rtl/wb_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_port #(
  parameter int unsigned MEM_WORDS = bus_pkg::MEM_WORDS_DEFAULT,
  parameter bit          WRITABLE  = 1'b1
) (
  input  logic           sys_clk,
  input  logic           arst_n_i,
  input  logic           host_sel_i,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  bus_pkg::addr_t wb_addr_i,
  input  bus_pkg::data_t wb_data_i,
  output bus_pkg::data_t wb_data_o,
  output logic           wb_ack_o,
  input  logic           h_req_i,
  input  logic           h_we_i,
  input  bus_pkg::addr_t h_addr_i,
  input  bus_pkg::data_t h_data_i,
  output bus_pkg::data_t h_rdata_o
);

  import bus_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  data_t            mem_q [MEM_WORDS];
  data_t            rdata_q;
  logic             ack_q;
  logic             core_req;
  logic             acc_rd;
  logic             acc_wr;
  addr_t            acc_addr;
  data_t            acc_wdata;
  logic [IDX_W-1:0] acc_idx;

  // Byte address to word slot, wrapping at the memory depth
  function automatic logic [IDX_W-1:0] word_idx(addr_t a);
    return IDX_W'((a >> WORD_LSB) % MEM_WORDS);
  endfunction

  // New core request, not sampled again in its own ack cycle
  assign core_req = !host_sel_i && wb_cyc_i && wb_stb_i && !ack_q;

  // Halt cuts an ack still in flight
  assign wb_ack_o = ack_q && !host_sel_i;

  always_comb begin
    if (host_sel_i) begin
      acc_addr  = h_addr_i;
      acc_wdata = h_data_i;
      acc_rd    = h_req_i && !h_we_i;
      acc_wr    = h_req_i && h_we_i; // Loading works on either side
    end else begin
      acc_addr  = wb_addr_i;
      acc_wdata = wb_data_i;
      acc_rd    = core_req;
      acc_wr    = WRITABLE && wb_ack_o && wb_cyc_i && wb_we_i; // Store lands with ack
    end
  end

  assign acc_idx = word_idx(acc_addr);

  // Single access per cycle
  always_ff @(posedge sys_clk) begin
    if (acc_wr) begin
      mem_q[acc_idx] <= acc_wdata;
    end
    if (acc_rd) begin
      rdata_q <= mem_q[acc_idx];
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= core_req; // High for one cycle per request
    end
  end

  // Only one side reads at a time, so one register serves both
  assign wb_data_o = rdata_q;
  assign h_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== test/procci_harness_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module procci_harness_assertions (
  input logic              sys_clk,
  input logic              arst_n_i,
  input logic              core_rst_n_i,
  input logic              ibus_cyc_i,
  input logic              ibus_ack_i,
  input logic              dbus_cyc_i,
  input logic              dbus_ack_i,
  input logic              rsp_valid_i,
  input host_pkg::credit_t rsp_credits_i
);

  int assert_errors = 0;

  // Ack is a one cycle pulse inside a bus cycle
  property p_ack_pulse(logic ack, logic cyc);
    @(posedge sys_clk) disable iff (!arst_n_i)
      ack |-> cyc ##1 !ack;
  endproperty

  a_ibus_ack: assert property (p_ack_pulse(ibus_ack_i, ibus_cyc_i))
    else begin
      assert_errors++;
      $error("instruction bus ack outside cyc or longer than one cycle");
    end

  a_dbus_ack: assert property (p_ack_pulse(dbus_ack_i, dbus_cyc_i))
    else begin
      assert_errors++;
      $error("data bus ack outside cyc or longer than one cycle");
    end

  a_rsp_credit: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
    rsp_valid_i |-> (rsp_credits_i != '0))
    else begin
      assert_errors++;
      $error("host response issued with no response credit");
    end

  // Held core gets nothing on either bus
  a_held_no_ack: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
    !core_rst_n_i |-> !ibus_ack_i && !dbus_ack_i)
    else begin
      assert_errors++;
      $error("bus ack while the core is held in reset");
    end

endmodule

bind procci_harness_top procci_harness_assertions u_assertions (
  .sys_clk       (sys_clk),
  .arst_n_i      (arst_n_i),
  .core_rst_n_i  (core_rst_n_o),
  .ibus_cyc_i    (core_cyc_i),
  .ibus_ack_i    (core_ack_o),
  .dbus_cyc_i    (data_mem_cyc_i),
  .dbus_ack_i    (data_mem_ack_o),
  .rsp_valid_i   (host_rsp_valid_o),
  .rsp_credits_i (u_engine.credits_q)
);

`default_nettype wire

// ==== test/procci_harness_vectors.txt ====
// kind op addr data expected, all hex, five words per line
// kind 0 host command, 1 core fetch, 2 core load(0)/store(1), 3 control, f end
3 0 00000000 00000000 00000000 // core requests while halted
0 0 00000000 00000013 00000000 // imem writes
0 0 00000004 00a00093 00000000
0 0 00000008 00108113 00000000
0 1 00000010 cafe0001 00000000 // dmem writes
0 1 00000404 beef0002 00000000 // wraps onto word 1
0 2 00000000 00000000 00000013 // host reads back
0 2 00000008 00000000 00108113
0 3 00000010 00000000 cafe0001
0 3 00000004 00000000 beef0002
3 3 00000000 00000000 00000000 // drain
0 4 00000000 00000000 00000000 // run
1 0 00000004 00000000 00a00093 // fetches
1 0 00000000 00000000 00000013
1 0 00000008 00000000 00108113
2 0 00000010 00000000 cafe0001 // load
2 1 00000020 12345678 00000000 // store then load back
2 0 00000020 00000000 12345678
2 1 00000014 a5a5a5a5 00000000
0 5 00000000 00000000 00000000 // halt
3 0 00000000 00000000 00000000
0 3 00000020 00000000 12345678 // host sees the core stores
0 3 00000014 00000000 a5a5a5a5
3 1 00000000 00000000 00000000 // withhold response credits
0 3 00000010 00000000 cafe0001
0 3 00000014 00000000 a5a5a5a5
0 3 00000020 00000000 12345678
0 3 00000004 00000000 beef0002
0 2 00000000 00000000 00000013
0 2 00000004 00000000 00a00093
0 2 00000008 00000000 00108113
3 2 00000000 00000000 00000005 // release, five reads held
3 3 00000000 00000000 00000000
f 0 00000000 00000000 00000000

// ==== test/tb_procci_harness.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_procci_harness;

  import bus_pkg::*;
  import host_pkg::*;

  localparam int unsigned MEM_WORDS   = MEM_WORDS_DEFAULT;
  localparam int unsigned CMD_DEPTH   = CMD_DEPTH_DEFAULT;
  localparam int unsigned RSP_CREDITS = RSP_CREDITS_DEFAULT;
  localparam int MAX_VEC        = 64;
  localparam int CYCLES_PER_VEC = 40;

  logic     sys_clk;
  logic     arst_n_i;
  logic     host_cmd_valid_i;
  host_op_t host_cmd_op_i;
  addr_t    host_cmd_addr_i;
  data_t    host_cmd_data_i;
  logic     host_cmd_credit_o;
  logic     host_rsp_valid_o;
  data_t    host_rsp_data_o;
  logic     host_rsp_credit_i;
  logic     core_rst_n_o;
  logic     core_cyc_i;
  logic     core_stb_i;
  addr_t    core_addr_i;
  data_t    core_data_o;
  logic     core_ack_o;
  logic     data_mem_cyc_i;
  logic     data_mem_stb_i;
  logic     data_mem_we_i;
  addr_t    data_mem_addr_i;
  data_t    data_mem_data_i;
  data_t    data_mem_data_o;
  logic     data_mem_ack_o;

  logic [31:0] vec_mem [5*MAX_VEC];
  data_t       imem_sh [MEM_WORDS]; // Shadow copies of both memories
  data_t       dmem_sh [MEM_WORDS];
  data_t       exp_q [$];           // Reads still waiting for a response
  credit_t     host_credits;
  logic        withhold = 1'b0;
  int          errors = 0;
  int          n_vec = 0;
  int          cycles = 0;
  int          timeout_lim = 0;
  int          push_cnt = 0;
  int          owed = 0;
  int          gap = 0;
  integer      seed = 32'h2173;

  procci_harness_top #(
    .MEM_WORDS   (MEM_WORDS),
    .CMD_DEPTH   (CMD_DEPTH),
    .RSP_CREDITS (RSP_CREDITS)
  ) u_procci_harness_top (
    .sys_clk           (sys_clk),
    .arst_n_i          (arst_n_i),
    .host_cmd_valid_i  (host_cmd_valid_i),
    .host_cmd_op_i     (host_cmd_op_i),
    .host_cmd_addr_i   (host_cmd_addr_i),
    .host_cmd_data_i   (host_cmd_data_i),
    .host_cmd_credit_o (host_cmd_credit_o),
    .host_rsp_valid_o  (host_rsp_valid_o),
    .host_rsp_data_o   (host_rsp_data_o),
    .host_rsp_credit_i (host_rsp_credit_i),
    .core_rst_n_o      (core_rst_n_o),
    .core_cyc_i        (core_cyc_i),
    .core_stb_i        (core_stb_i),
    .core_addr_i       (core_addr_i),
    .core_data_o       (core_data_o),
    .core_ack_o        (core_ack_o),
    .data_mem_cyc_i    (data_mem_cyc_i),
    .data_mem_stb_i    (data_mem_stb_i),
    .data_mem_we_i     (data_mem_we_i),
    .data_mem_addr_i   (data_mem_addr_i),
    .data_mem_data_i   (data_mem_data_i),
    .data_mem_data_o   (data_mem_data_o),
    .data_mem_ack_o    (data_mem_ack_o)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_ctrl(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d vectors, %0d check errors, %0d assertion failures",
             n_vec, errors, u_procci_harness_top.u_assertions.assert_errors);
  endtask

  // Word slot from byte address wraps at the depth
  function automatic int slot(input addr_t a);
    return int'(a[ADDR_W-1:2] % MEM_WORDS);
  endfunction

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (timeout_lim > 0 && cycles >= timeout_lim) begin
      $display("ERROR: run not finished after %0d cycles, %0d host responses never arrived",
               timeout_lim, exp_q.size());
      print_summary();
      $display("Test failed");
      $finish;
    end
  end

  // Host view of command credits
  always @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      host_credits <= credit_t'(CMD_DEPTH);
    end else begin
      host_credits <= host_credits + host_cmd_credit_o - host_cmd_valid_i;
    end
  end

  // Response collector returns credits after a random gap
  always @(posedge sys_clk) begin
    host_rsp_credit_i <= 1'b0;
    if (arst_n_i) begin
      if (host_rsp_valid_o) begin
        owed = owed + 1;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR: host response 0x%h arrived with no read outstanding",
                   host_rsp_data_o);
        end else begin
          check_word("host_rsp_data_o", host_rsp_data_o, exp_q.pop_front());
        end
      end
      if (owed > 0 && !withhold) begin
        if (gap == 0) begin
          host_rsp_credit_i <= 1'b1;
          owed = owed - 1;
          gap  = $random(seed) & 3;
        end else begin
          gap = gap - 1;
        end
      end
    end
  end

  task automatic step();
    @(posedge sys_clk);
    host_cmd_valid_i <= 1'b0; // A push lasts one cycle
  endtask

  task automatic push_cmd(input host_op_t op, input addr_t addr, input data_t data);
    int avail;
    step();
    avail = int'(host_credits) - int'(host_cmd_valid_i);
    if (push_cnt == 0) begin
      // Nothing popped yet, so no credit may have come back
      check_ctrl("host_cmd_credits", host_credits == credit_t'(CMD_DEPTH), 1'b1);
    end
    while (avail <= 0) begin
      step();
      avail = int'(host_credits) - int'(host_cmd_valid_i);
    end
    host_cmd_valid_i <= 1'b1;
    host_cmd_op_i    <= op;
    host_cmd_addr_i  <= addr;
    host_cmd_data_i  <= data;
    push_cnt++;
  endtask

  task automatic wait_responses();
    step();
    while (exp_q.size() != 0) begin
      @(negedge sys_clk);
    end
  endtask

  task automatic model_agrees(input int idx, input data_t model, input data_t col);
    if (model !== col) begin
      errors++;
      $display("ERROR: vector %0d expects 0x%h but the memory model holds 0x%h",
               idx, col, model);
    end
  endtask

  // Core model holds cyc and stb until ack
  task automatic core_access(input logic dbus, input logic we, input addr_t addr,
                             input data_t wdata, output data_t rdata);
    step();
    if (dbus) begin
      data_mem_cyc_i  <= 1'b1;
      data_mem_stb_i  <= 1'b1;
      data_mem_we_i   <= we;
      data_mem_addr_i <= addr;
      data_mem_data_i <= wdata;
    end else begin
      core_cyc_i  <= 1'b1;
      core_stb_i  <= 1'b1;
      core_addr_i <= addr;
    end
    do begin
      step();
    end while (!(dbus ? data_mem_ack_o : core_ack_o));
    rdata = dbus ? data_mem_data_o : core_data_o;
    core_cyc_i     <= 1'b0;
    core_stb_i     <= 1'b0;
    data_mem_cyc_i <= 1'b0;
    data_mem_stb_i <= 1'b0;
    data_mem_we_i  <= 1'b0;
  endtask

  task automatic host_command(input int idx, input host_op_t op, input addr_t addr,
                              input data_t data, input data_t exp);
    data_t model;
    case (op)
      OP_IMEM_WRITE: begin
        push_cmd(op, addr, data);
        imem_sh[slot(addr)] = data;
      end
      OP_DMEM_WRITE: begin
        push_cmd(op, addr, data);
        dmem_sh[slot(addr)] = data;
      end
      OP_IMEM_READ, OP_DMEM_READ: begin
        model = (op == OP_IMEM_READ) ? imem_sh[slot(addr)] : dmem_sh[slot(addr)];
        model_agrees(idx, model, exp);
        push_cmd(op, addr, data);
        exp_q.push_back(model);
      end
      default: begin // Run or halt
        wait_responses();
        check_ctrl("core_rst_n_o", core_rst_n_o, op == OP_CORE_HALT);
        push_cmd(op, addr, data);
        step();
        while (core_rst_n_o !== (op == OP_CORE_RUN)) begin
          @(negedge sys_clk);
        end
      end
    endcase
  endtask

  task automatic control(input logic [1:0] op, input data_t exp);
    case (op)
      2'd0: begin
        step();
        core_cyc_i     <= 1'b1;
        core_stb_i     <= 1'b1;
        data_mem_cyc_i <= 1'b1;
        data_mem_stb_i <= 1'b1;
        repeat (6) begin
          step();
          check_ctrl("core_ack_o", core_ack_o, 1'b0);
          check_ctrl("data_mem_ack_o", data_mem_ack_o, 1'b0);
        end
        check_ctrl("core_rst_n_o", core_rst_n_o, 1'b0);
        core_cyc_i     <= 1'b0;
        core_stb_i     <= 1'b0;
        data_mem_cyc_i <= 1'b0;
        data_mem_stb_i <= 1'b0;
      end
      2'd1: begin
        // Engine starts with all its response credits
        wait_responses();
        do begin
          @(negedge sys_clk);
        end while (owed != 0);
        withhold = 1'b1;
      end
      2'd2: begin
        // FIFO full behind a stalled read, so no credit comes back
        repeat (8) begin
          step();
          check_ctrl("host_cmd_credit_o", host_cmd_credit_o, 1'b0);
        end
        @(negedge sys_clk);
        check_ctrl("host_cmd_credits_empty", host_credits == '0, 1'b1);
        check_ctrl("rsp_held", exp_q.size() == int'(exp), 1'b1);
        withhold = 1'b0;
        wait_responses();
      end
      default: begin
        wait_responses();
        repeat (4) step();
        check_ctrl("host_cmd_credits_full", host_credits == credit_t'(CMD_DEPTH), 1'b1);
      end
    endcase
  endtask

  task automatic run_vector(input int i);
    logic [3:0] kind;
    addr_t      addr;
    data_t      data;
    data_t      exp;
    data_t      got;
    kind = vec_mem[5*i][3:0];
    addr = vec_mem[5*i+2];
    data = vec_mem[5*i+3];
    exp  = vec_mem[5*i+4];
    case (kind)
      4'h0: host_command(i, host_op_t'(vec_mem[5*i+1][2:0]), addr, data, exp);
      4'h1: begin
        model_agrees(i, imem_sh[slot(addr)], exp);
        core_access(1'b0, 1'b0, addr, '0, got);
        check_word("core_data_o", got, imem_sh[slot(addr)]);
      end
      4'h2: begin
        if (vec_mem[5*i+1][0]) begin
          core_access(1'b1, 1'b1, addr, data, got);
          dmem_sh[slot(addr)] = data;
        end else begin
          model_agrees(i, dmem_sh[slot(addr)], exp);
          core_access(1'b1, 1'b0, addr, '0, got);
          check_word("data_mem_data_o", got, dmem_sh[slot(addr)]);
        end
      end
      4'h3: control(vec_mem[5*i+1][1:0], exp);
      default: begin
        errors++;
        $display("ERROR: vector %0d has unknown kind %0h", i, kind);
      end
    endcase
  endtask

  initial begin
    arst_n_i          = 1'b0;
    host_cmd_valid_i  = 1'b0;
    host_cmd_op_i     = OP_IMEM_WRITE;
    host_cmd_addr_i   = '0;
    host_cmd_data_i   = '0;
    host_rsp_credit_i = 1'b0;
    core_cyc_i        = 1'b0;
    core_stb_i        = 1'b0;
    core_addr_i       = '0;
    data_mem_cyc_i    = 1'b0;
    data_mem_stb_i    = 1'b0;
    data_mem_we_i     = 1'b0;
    data_mem_addr_i   = '0;
    data_mem_data_i   = '0;
    $readmemh("test/procci_harness_vectors.txt", vec_mem);
    while (n_vec < MAX_VEC && vec_mem[5*n_vec] !== 32'hf &&
           !$isunknown(vec_mem[5*n_vec])) begin
      n_vec++;
    end
    if (n_vec == 0) begin
      errors++;
      $display("ERROR: no vectors found in the vector file");
    end
    timeout_lim = n_vec * CYCLES_PER_VEC;
    repeat (16) @(posedge sys_clk);
    arst_n_i <= 1'b1;
    step();
    // Quiet outputs straight after reset
    check_ctrl("core_rst_n_o", core_rst_n_o, 1'b0);
    check_ctrl("host_rsp_valid_o", host_rsp_valid_o, 1'b0);
    check_ctrl("host_cmd_credit_o", host_cmd_credit_o, 1'b0);
    check_ctrl("core_ack_o", core_ack_o, 1'b0);
    check_ctrl("data_mem_ack_o", data_mem_ack_o, 1'b0);
    for (int i = 0; i < n_vec; i++) begin
      run_vector(i);
    end
    wait_responses();
    repeat (4) step();
    print_summary();
    if (errors == 0 && u_procci_harness_top.u_assertions.assert_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
